//--- Makefile
# Verilator lint, build and simulation of the GPIO block

VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
# Verilator runtime seed, the stimulus seed is fixed in the testbench
SEED      ?= 1
VFLAGS    ?= --timing --assert
PASS_MSG  := Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides pass or fail, not the exit code of the pipe
sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/gpio_apb_regs.sv
// GPIO APB register file
// Decodes APB accesses, merges written bytes into the configuration
// registers, forms the status clear mask and registers read data

`include "gpio_settings.svh"

module gpio_apb_regs
  import gpio_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       PSEL,
  input  logic       PENABLE,
  input  logic       PWRITE,
  input  gpio_addr_t PADDR,
  input  gpio_strb_t PSTRB,
  input  gpio_data_t PWDATA,
  input  gpio_data_t in_val,
  input  gpio_data_t stat,
  output gpio_data_t PRDATA,
  output gpio_cfg_t  cfg,
  output gpio_data_t stat_clr
);

  ////////////////////
  // Access decode
  ////////////////////

  // Write access phase, never stalled
  logic       wr_en;
  gpio_cfg_t  cfg_q;

  assign wr_en = PSEL & PENABLE & PWRITE;

  // Byte lane merge
  // Lanes with a strobe take the new byte, others keep orig
  function automatic gpio_data_t merge_lanes(
    input gpio_data_t orig,
    input gpio_data_t wdata,
    input gpio_strb_t strb
  );
    gpio_data_t res;
    for (int n = 0; n < `GPIO_STRB_W; n++) begin
      res[n*8 +: 8] = strb[n] ? wdata[n*8 +: 8] : orig[n*8 +: 8];
    end
    return res;
  endfunction

  ////////////////////
  // Config registers
  ////////////////////

  // One write per access, selected by word address
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (PADDR)
        `GPIO_ADR_MODE: begin
          cfg_q.mode <= merge_lanes(cfg_q.mode, PWDATA, PSTRB);
        end
        `GPIO_ADR_DIR: begin
          cfg_q.dir <= merge_lanes(cfg_q.dir, PWDATA, PSTRB);
        end
        // Input offset is read-only, writes land in the output register
        `GPIO_ADR_OUT, `GPIO_ADR_IN: begin
          cfg_q.out <= merge_lanes(cfg_q.out, PWDATA, PSTRB);
        end
        `GPIO_ADR_TR_TYPE: begin
          cfg_q.tr_type <= merge_lanes(cfg_q.tr_type, PWDATA, PSTRB);
        end
        `GPIO_ADR_TR_LVL0: begin
          cfg_q.tr_lvl0 <= merge_lanes(cfg_q.tr_lvl0, PWDATA, PSTRB);
        end
        `GPIO_ADR_TR_LVL1: begin
          cfg_q.tr_lvl1 <= merge_lanes(cfg_q.tr_lvl1, PWDATA, PSTRB);
        end
        `GPIO_ADR_IRQ_ENA: begin
          cfg_q.irq_ena <= merge_lanes(cfg_q.irq_ena, PWDATA, PSTRB);
        end
        // Status handled in the trigger unit
        default: begin
        end
      endcase
    end
  end

  assign cfg = cfg_q;

  // Write-one-to-clear mask
  // Strobe-masked write data, only on a status write
  always_comb begin
    stat_clr = '0;
    if (wr_en && (PADDR == `GPIO_ADR_TR_STAT)) begin
      stat_clr = merge_lanes('0, PWDATA, PSTRB);
    end
  end

  ////////////////////
  // Read data
  ////////////////////

  // Registered from PADDR on every edge
  // Valid through the access phase
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      PRDATA <= '0;
    end else begin
      case (PADDR)
        `GPIO_ADR_MODE:    PRDATA <= cfg_q.mode;
        `GPIO_ADR_DIR:     PRDATA <= cfg_q.dir;
        `GPIO_ADR_OUT:     PRDATA <= cfg_q.out;
        `GPIO_ADR_IN:      PRDATA <= in_val;
        `GPIO_ADR_TR_TYPE: PRDATA <= cfg_q.tr_type;
        `GPIO_ADR_TR_LVL0: PRDATA <= cfg_q.tr_lvl0;
        `GPIO_ADR_TR_LVL1: PRDATA <= cfg_q.tr_lvl1;
        `GPIO_ADR_TR_STAT: PRDATA <= stat;
        `GPIO_ADR_IRQ_ENA: PRDATA <= cfg_q.irq_ena;
        // Unmapped offsets
        default:           PRDATA <= '0;
      endcase
    end
  end

endmodule

//--- design/gpio_input_sync.sv
// GPIO input synchroniser
// Flop chain on the asynchronous pin inputs, then the sampling
// register that holds the architectural input value

`include "gpio_settings.svh"

module gpio_input_sync
  import gpio_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  gpio_data_t gpio_i,
  output gpio_data_t in_val
);

  // Metastability chain, stage 0 samples the pins
  gpio_data_t sync_q [`GPIO_SYNC_STAGES];

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      for (int n = 0; n < `GPIO_SYNC_STAGES; n++) begin
        sync_q[n] <= '0;
      end
      in_val <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      for (int n = 1; n < `GPIO_SYNC_STAGES; n++) begin
        sync_q[n] <= sync_q[n-1];
      end
      // Sampling register, what software reads
      in_val <= sync_q[`GPIO_SYNC_STAGES-1];
    end
  end

endmodule

//--- design/gpio_pad_ctrl.sv
// GPIO pad control
// Registered drive value and output enable per pin, push-pull or
// open-drain as selected by the mode register

module gpio_pad_ctrl
  import gpio_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  gpio_cfg_t  cfg,
  output gpio_data_t gpio_o,
  output gpio_data_t gpio_oe
);

  // mode  dir  out   drive
  // -     0    -     Hi-Z, input only
  // 0     1    v     drive v
  // 1     1    0     drive low
  // 1     1    1     Hi-Z, released
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      gpio_o  <= '0;
      gpio_oe <= '0;
    end else begin
      // Open-drain never drives a one
      gpio_o  <= cfg.out & ~cfg.mode;
      // Open-drain with out high releases the pin
      gpio_oe <= cfg.dir & ~(cfg.mode & cfg.out);
    end
  end

endmodule

//--- design/gpio_pkg.sv
// GPIO types
// Vector types for pins, addresses and strobes, and the configuration
// state shared between the register file, pad control and trigger unit

`include "gpio_settings.svh"

package gpio_pkg;

  ////////////////////
  // Vector types
  ////////////////////

  // One bit per pin, also the APB data word
  typedef logic [`GPIO_DATA_W-1:0] gpio_data_t;
  // APB word address
  typedef logic [`GPIO_ADDR_W-1:0] gpio_addr_t;
  // Byte lane strobes
  typedef logic [`GPIO_STRB_W-1:0] gpio_strb_t;

  ////////////////////
  // Configuration
  ////////////////////

  // Software visible control registers
  typedef struct packed {
    gpio_data_t mode;     // 1 = open-drain, 0 = push-pull
    gpio_data_t dir;      // 1 = output
    gpio_data_t out;      // Output value
    gpio_data_t tr_type;  // 1 = edge, 0 = level
    gpio_data_t tr_lvl0;  // Low level or falling edge
    gpio_data_t tr_lvl1;  // High level or rising edge
    gpio_data_t irq_ena;  // Interrupt enable
  } gpio_cfg_t;

endpackage

//--- design/gpio_settings.svh
// GPIO block settings
// Pin count, bus widths, synchroniser depth and the APB register map

`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// Pin count and APB data width, must be a multiple of 8
`define GPIO_DATA_W 32
// Word address width
`define GPIO_ADDR_W 4
// One strobe per byte lane
`define GPIO_STRB_W (`GPIO_DATA_W/8)
// Synchroniser depth on the pin inputs, at least 2
`define GPIO_SYNC_STAGES 2

// Register offsets
`define GPIO_ADR_MODE     `GPIO_ADDR_W'(0)
`define GPIO_ADR_DIR      `GPIO_ADDR_W'(1)
`define GPIO_ADR_OUT      `GPIO_ADDR_W'(2)
`define GPIO_ADR_IN       `GPIO_ADDR_W'(3)
`define GPIO_ADR_TR_TYPE  `GPIO_ADDR_W'(4)
`define GPIO_ADR_TR_LVL0  `GPIO_ADDR_W'(5)
`define GPIO_ADR_TR_LVL1  `GPIO_ADDR_W'(6)
`define GPIO_ADR_TR_STAT  `GPIO_ADDR_W'(7)
`define GPIO_ADR_IRQ_ENA  `GPIO_ADDR_W'(8)

`endif

//--- design/gpio_top.sv
// GPIO top level
// 32-pin general purpose I/O on APB. Zero wait states, no error
// response. Pads are external, the block drives gpio_o and gpio_oe

module gpio_top
  import gpio_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       PSEL,
  input  logic       PENABLE,
  input  logic       PWRITE,
  input  gpio_addr_t PADDR,
  input  gpio_strb_t PSTRB,
  input  gpio_data_t PWDATA,
  output gpio_data_t PRDATA,
  output logic       PREADY,
  output logic       PSLVERR,
  output logic       irq,
  input  gpio_data_t gpio_i,
  output gpio_data_t gpio_o,
  output gpio_data_t gpio_oe
);

  gpio_cfg_t  cfg;
  gpio_data_t stat_clr;
  gpio_data_t stat;
  gpio_data_t in_val;

  // Never stalls, never errors
  assign PREADY  = 1'b1;
  assign PSLVERR = 1'b0;

  // Register file, sole APB slave
  gpio_apb_regs u_regs (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PWRITE   (PWRITE),
    .PADDR    (PADDR),
    .PSTRB    (PSTRB),
    .PWDATA   (PWDATA),
    .in_val   (in_val),
    .stat     (stat),
    .PRDATA   (PRDATA),
    .cfg      (cfg),
    .stat_clr (stat_clr)
  );

  // Pin inputs into the clock domain
  gpio_input_sync u_sync (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .gpio_i  (gpio_i),
    .in_val  (in_val)
  );

  // Output drive
  gpio_pad_ctrl u_pad (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .cfg     (cfg),
    .gpio_o  (gpio_o),
    .gpio_oe (gpio_oe)
  );

  // Triggers and interrupt
  gpio_trigger u_trig (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .in_val   (in_val),
    .cfg      (cfg),
    .stat_clr (stat_clr),
    .stat     (stat),
    .irq      (irq)
  );

endmodule

//--- design/gpio_trigger.sv
// GPIO trigger and interrupt unit
// Edge detection on the sampled inputs, level or edge trigger per pin,
// sticky status with write-one-to-clear and the interrupt output

module gpio_trigger
  import gpio_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  gpio_data_t in_val,
  input  gpio_cfg_t  cfg,
  input  gpio_data_t stat_clr,
  output gpio_data_t stat,
  output logic       irq
);

  gpio_data_t in_dly_q;
  gpio_data_t rise_q;
  gpio_data_t fall_q;
  gpio_data_t lvl_hit;
  gpio_data_t edge_hit;
  gpio_data_t hit;

  ////////////////////
  // Edge detect
  ////////////////////

  // Edges registered, one cycle behind in_val
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      in_dly_q <= '0;
      rise_q   <= '0;
      fall_q   <= '0;
    end else begin
      in_dly_q <= in_val;
      rise_q   <= in_val & ~in_dly_q;
      fall_q   <= in_dly_q & ~in_val;
    end
  end

  ////////////////////
  // Trigger eval
  ////////////////////

  // lvl0 selects low level / falling edge, lvl1 high level / rising edge
  assign lvl_hit  = (cfg.tr_lvl0 & ~in_val) | (cfg.tr_lvl1 & in_val);
  assign edge_hit = (cfg.tr_lvl0 & fall_q) | (cfg.tr_lvl1 & rise_q);
  assign hit      = (~cfg.tr_type & lvl_hit) | (cfg.tr_type & edge_hit);

  // Sticky status, a new hit wins over a clear in the same cycle
  // Interrupt follows status one cycle later
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      stat <= '0;
      irq  <= 1'b0;
    end else begin
      stat <= (stat & ~stat_clr) | hit;
      irq  <= |(cfg.irq_ena & stat);
    end
  end

endmodule

//--- project.f
+incdir+design
design/gpio_pkg.sv
design/gpio_apb_regs.sv
design/gpio_input_sync.sv
design/gpio_pad_ctrl.sv
design/gpio_trigger.sv
design/gpio_top.sv
verification/gpio_asserts.sv
verification/gpio_tb.sv

//--- verification/gpio_asserts.sv
// GPIO bound checks
// Bus response, pad drive against the previous configuration and
// the interrupt against the previous enabled status

module gpio_asserts
  import gpio_pkg::*;
(
  input logic       PCLK,
  input logic       PRESETn,
  input logic       PREADY,
  input logic       PSLVERR,
  input logic       irq,
  input gpio_cfg_t  cfg,
  input gpio_data_t stat,
  input gpio_data_t gpio_o,
  input gpio_data_t gpio_oe
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // Bus response
  ////////////////////

  // Zero wait states, no error response
  ready_high: assert property (@(posedge PCLK) PREADY)
    else $error("PREADY went low");
  slverr_low: assert property (@(posedge PCLK) !PSLVERR)
    else $error("PSLVERR went high");

  ////////////////////
  // Pads and interrupt
  ////////////////////

  // Only pins set as outputs one cycle earlier may be enabled
  oe_needs_dir: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (gpio_oe & ~$past(cfg.dir)) == '0)
    else $error("Output enable on a pin that is not an output");
  // Open-drain pins never drive a one
  od_never_high: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (gpio_o & $past(cfg.mode)) == '0)
    else $error("Open-drain pin driven high");
  // Registered OR of enabled status
  irq_from_stat: assert property (@(posedge PCLK) disable iff (!PRESETn)
    irq == |($past(cfg.irq_ena) & $past(stat)))
    else $error("Interrupt does not follow enabled status");

endmodule

// Config and status are visible as wires in the top level
bind gpio_top gpio_asserts u_asserts (
  .PCLK    (PCLK),
  .PRESETn (PRESETn),
  .PREADY  (PREADY),
  .PSLVERR (PSLVERR),
  .irq     (irq),
  .cfg     (cfg),
  .stat    (stat),
  .gpio_o  (gpio_o),
  .gpio_oe (gpio_oe)
);

//--- verification/gpio_tb.sv
// GPIO testbench
// Random APB traffic and pin stimulus against a register level model,
// checked on read data, pad drive and the interrupt

`include "gpio_settings.svh"

module gpio_tb
  import gpio_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_OPS      = 400;
  // At most 12 cycles per op, the rest covers reset and the first reads
  localparam int TIMEOUT_CYCLES = 20 * NUM_OPS;
  // Pin to status takes 5 edges, status to irq one more
  localparam int INPUT_SETTLE = 8;
  localparam int WRITE_SETTLE = 3;

  logic       PCLK = 1'b0;
  logic       PRESETn;
  logic       PSEL;
  logic       PENABLE;
  logic       PWRITE;
  gpio_addr_t PADDR;
  gpio_strb_t PSTRB;
  gpio_data_t PWDATA;
  gpio_data_t PRDATA;
  logic       PREADY;
  logic       PSLVERR;
  logic       irq;
  gpio_data_t gpio_i;
  gpio_data_t gpio_o;
  gpio_data_t gpio_oe;

  // Model state
  gpio_cfg_t   m_cfg;
  gpio_data_t  m_stat;
  gpio_data_t  m_in;
  integer      seed = 5913;
  int          err_cnt = 0;
  int unsigned cycle_cnt = 0;

  always #2 PCLK = ~PCLK;

  gpio_top DUT (.*);

  // Run limit
  always @(posedge PCLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1, "Run stopped by timeout");
    end
  end

  ////////////////////
  // Model
  ////////////////////

  // Strobes widened to one mask bit per data bit
  function automatic gpio_data_t lane_mask(input gpio_strb_t s);
    gpio_data_t m;
    for (int b = 0; b < `GPIO_DATA_W; b++) begin
      m[b] = s[b/8];
    end
    return m;
  endfunction

  // Level type pins that see their selected level
  function automatic gpio_data_t level_hits(input gpio_cfg_t c, input gpio_data_t v);
    return ~c.tr_type & ((c.tr_lvl0 & ~v) | (c.tr_lvl1 & v));
  endfunction

  // Edge type pins with a selected edge between two settled values
  function automatic gpio_data_t edge_hits(input gpio_cfg_t c, input gpio_data_t was,
                                           input gpio_data_t now);
    return c.tr_type & ((c.tr_lvl0 & was & ~now) | (c.tr_lvl1 & ~was & now));
  endfunction

  // Expected pad drive per pin from the mode table
  function automatic void pad_expect(input gpio_cfg_t c, output gpio_data_t o,
                                     output gpio_data_t oe);
    for (int p = 0; p < `GPIO_DATA_W; p++) begin
      if (c.mode[p]) begin
        // Open-drain pulls low or releases
        o[p]  = 1'b0;
        oe[p] = c.dir[p] && !c.out[p];
      end else begin
        // Push-pull drives the output value
        o[p]  = c.out[p];
        oe[p] = c.dir[p];
      end
    end
  endfunction

  function automatic void model_write(input gpio_addr_t a, input gpio_data_t d,
                                      input gpio_strb_t s);
    gpio_data_t mask;
    mask = lane_mask(s);
    case (a)
      `GPIO_ADR_MODE:    m_cfg.mode    = (m_cfg.mode & ~mask) | (d & mask);
      `GPIO_ADR_DIR:     m_cfg.dir     = (m_cfg.dir & ~mask) | (d & mask);
      // Input offset aliases the output register
      `GPIO_ADR_OUT, `GPIO_ADR_IN: m_cfg.out = (m_cfg.out & ~mask) | (d & mask);
      `GPIO_ADR_TR_TYPE: m_cfg.tr_type = (m_cfg.tr_type & ~mask) | (d & mask);
      `GPIO_ADR_TR_LVL0: m_cfg.tr_lvl0 = (m_cfg.tr_lvl0 & ~mask) | (d & mask);
      `GPIO_ADR_TR_LVL1: m_cfg.tr_lvl1 = (m_cfg.tr_lvl1 & ~mask) | (d & mask);
      `GPIO_ADR_IRQ_ENA: m_cfg.irq_ena = (m_cfg.irq_ena & ~mask) | (d & mask);
      `GPIO_ADR_TR_STAT: m_stat        = m_stat & ~(d & mask);
      default: begin
      end
    endcase
    // Steady levels set status again, also right after a clear
    m_stat = m_stat | level_hits(m_cfg, m_in);
  endfunction

  function automatic gpio_data_t expected_read(input gpio_addr_t a);
    case (a)
      `GPIO_ADR_MODE:    return m_cfg.mode;
      `GPIO_ADR_DIR:     return m_cfg.dir;
      `GPIO_ADR_OUT:     return m_cfg.out;
      `GPIO_ADR_IN:      return m_in;
      `GPIO_ADR_TR_TYPE: return m_cfg.tr_type;
      `GPIO_ADR_TR_LVL0: return m_cfg.tr_lvl0;
      `GPIO_ADR_TR_LVL1: return m_cfg.tr_lvl1;
      `GPIO_ADR_TR_STAT: return m_stat;
      `GPIO_ADR_IRQ_ENA: return m_cfg.irq_ena;
      default:           return '0;
    endcase
  endfunction

  function automatic string reg_name(input gpio_addr_t a);
    string names [9] = '{"mode", "dir", "out", "in", "tr_type", "tr_lvl0", "tr_lvl1",
                         "tr_stat", "irq_ena"};
    return (a < 9) ? names[a] : "unmapped";
  endfunction

  ////////////////////
  // APB driver
  ////////////////////

  // Setup, then access until PREADY, sampled mid cycle
  task automatic write_reg(input gpio_addr_t a, input gpio_data_t d, input gpio_strb_t s);
    logic rdy;
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= a;
    PWDATA  <= d;
    PSTRB   <= s;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    do begin
      @(negedge PCLK);
      rdy = PREADY;
      check_value("PSLVERR", gpio_data_t'(PSLVERR), '0);
      @(posedge PCLK);
    end while (!rdy);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  task automatic read_reg(input gpio_addr_t a, output gpio_data_t d);
    logic rdy;
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= a;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    do begin
      @(negedge PCLK);
      rdy = PREADY;
      d   = PRDATA;
      check_value("PSLVERR", gpio_data_t'(PSLVERR), '0);
      @(posedge PCLK);
    end while (!rdy);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  ////////////////////
  // Checks and ops
  ////////////////////

  task automatic check_value(input string what, input gpio_data_t got, input gpio_data_t exp);
    assert (got === exp)
    else begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Pad drive and interrupt from the model, mid cycle
  task automatic check_pins();
    gpio_data_t exp_o;
    gpio_data_t exp_oe;
    @(negedge PCLK);
    pad_expect(m_cfg, exp_o, exp_oe);
    check_value("gpio_o", gpio_o, exp_o);
    check_value("gpio_oe", gpio_oe, exp_oe);
    check_value("irq", gpio_data_t'(irq), gpio_data_t'((m_cfg.irq_ena & m_stat) != '0));
  endtask

  // Write, read straight back, settle
  task automatic write_and_check(input gpio_addr_t a, input gpio_data_t d,
                                 input gpio_strb_t s);
    gpio_data_t rdata;
    gpio_addr_t rb;
    write_reg(a, d, s);
    model_write(a, d, s);
    rb = (a == `GPIO_ADR_IN) ? `GPIO_ADR_OUT : a;
    read_reg(rb, rdata);
    check_value(reg_name(rb), rdata, expected_read(rb));
    repeat (WRITE_SETTLE) @(posedge PCLK);
    check_pins();
  endtask

  task automatic read_and_check(input gpio_addr_t a);
    gpio_data_t rdata;
    read_reg(a, rdata);
    check_value(reg_name(a), rdata, expected_read(a));
    check_pins();
  endtask

  // All pins change at once, then settle
  task automatic change_inputs(input gpio_data_t v);
    @(posedge PCLK);
    gpio_i <= v;
    m_stat = m_stat | edge_hits(m_cfg, m_in, v) | level_hits(m_cfg, v);
    m_in   = v;
    repeat (INPUT_SETTLE) @(posedge PCLK);
    check_pins();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int op;
    PRESETn = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PSTRB   = '0;
    PWDATA  = '0;
    gpio_i  = '0;
    m_cfg   = '0;
    m_stat  = '0;
    m_in    = '0;
    repeat (RESET_CYCLES) @(posedge PCLK);
    PRESETn <= 1'b1;

    // Everything zero out of reset
    check_pins();
    for (int a = 0; a < 16; a++) begin
      read_and_check(gpio_addr_t'(a));
    end

    // Mix of writes, input changes, reads and status clears
    for (int i = 0; i < NUM_OPS; i++) begin
      op = $unsigned($random(seed)) % 10;
      if (op < 4) begin
        write_and_check(gpio_addr_t'($random(seed)), gpio_data_t'($random(seed)),
                        gpio_strb_t'($random(seed)));
      end else if (op < 6) begin
        change_inputs(gpio_data_t'($random(seed)));
      end else if (op < 9) begin
        read_and_check(gpio_addr_t'($random(seed)));
      end else begin
        // Partial write-one-to-clear
        write_and_check(`GPIO_ADR_TR_STAT, gpio_data_t'($random(seed)),
                        gpio_strb_t'($random(seed)));
      end
    end

    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
